/* list.f */
+incdir+include
design/fabric_msg_pkg.sv
design/xbar_ctrl_pkg.sv
design/credit_fifo.sv
design/cmd_router.sv
design/xbar_lane.sv
design/rsp_arbiter.sv
design/fabric_top.sv
testbench/tb_fabric_top.sv

/* Bender.yml */
package:
  name: fabric

sources:
  - include_dirs:
      - include
    files:
      - design/fabric_msg_pkg.sv
      - design/xbar_ctrl_pkg.sv
      - design/credit_fifo.sv
      - design/cmd_router.sv
      - design/xbar_lane.sv
      - design/rsp_arbiter.sv
      - design/fabric_top.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - testbench/tb_fabric_top.sv

/* testbench/tb_fabric_top.sv */
`default_nettype none

`include "fabric_params.svh"

module tb_fabric_top
  import fabric_msg_pkg::*;
  import xbar_ctrl_pkg::*;
();

  localparam int CLK_PERIOD = 40;
  localparam int DRIVE_DLY = 2;
  localparam int RESET_CYCLES = 8;
  localparam int IDLE_CYCLES = 4;
  localparam int NUM_SRC = `NUM_LANES + 1;
  // commands per phase
  localparam int N_LOOP = 6;
  localparam int N_LANE = 4 * `NUM_LANES;
  localparam int N_CFG = 2 + 6 + 3;
  localparam int N_DROP = 8;
  localparam int N_BP = 12;
  localparam int NUM_CMDS = N_LOOP + N_LANE + N_CFG + N_DROP + N_BP;
  localparam int PER_CMD_CYCLES = 16;
  localparam int HOLD_CYCLES = 60;
  localparam int SETTLE_CYCLES = 20;
  localparam int CYCLE_LIMIT = RESET_CYCLES + IDLE_CYCLES + NUM_CMDS * PER_CMD_CYCLES
                               + HOLD_CYCLES + SETTLE_CYCLES;

  logic       clk_i;
  logic       reset_i;
  logic       reset_q;
  logic       cmd_valid_i;
  cmd_addr_t  cmd_addr_i;
  data_word_t cmd_data_i;
  logic       cmd_credit_o;
  logic       rsp_valid_o;
  data_word_t rsp_data_o;
  src_tag_t   rsp_src_o;
  logic       rsp_credit_i;

  data_word_t  exp_q [NUM_SRC][$];
  logic        in_fwd [`NUM_LANES];
  logic        out_fwd [`NUM_LANES];
  logic [31:0] lcg_state = 32'd62119;
  int cycle = 0;
  int cmd_cred = `FIFO_DEPTH;
  int sent_count = 0;
  int credits_seen = 0;
  int rsp_owed = `FIFO_DEPTH;
  int rsp_pending = 0;
  int hold_until = 0;
  int data_errs = 0;
  int proto_errs = 0;

  fabric_top i_fabric_top (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .cmd_valid_i (cmd_valid_i),
    .cmd_addr_i  (cmd_addr_i),
    .cmd_data_i  (cmd_data_i),
    .cmd_credit_o(cmd_credit_o),
    .rsp_valid_o (rsp_valid_o),
    .rsp_data_o  (rsp_data_o),
    .rsp_src_o   (rsp_src_o),
    .rsp_credit_i(rsp_credit_i)
  );

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cycle = cycle + 1;
    reset_q <= reset_i;
  end

  // ==============================
  // reference model
  // ==============================
  function automatic data_word_t rand_word();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state[31:16];
  endfunction

  // follow the ring from the inject input, -1 when the word never returns
  function automatic int route_tag(input cmd_addr_t addr);
    int lane;
    if (addr == cmd_addr_t'(`LOOPBACK_ADDR)) return int'(LOOP_TAG);
    if (addr >= 2 * `NUM_LANES || addr[0]) return -1;
    lane = int'(addr) / 2;
    if (in_fwd[lane]) return -1;
    for (int hop = 0; hop < `NUM_LANES; hop++) begin
      if (!out_fwd[lane]) return lane;
      lane = (lane + 1) % `NUM_LANES;
      if (!in_fwd[lane]) return -1;
    end
    return -1;
  endfunction

  function automatic int words_expected();
    int total;
    total = 0;
    for (int s = 0; s < NUM_SRC; s++) begin
      total += exp_q[s].size();
    end
    return total;
  endfunction

  task automatic issue(input cmd_addr_t addr, input data_word_t data);
    int tag;
    xbar_word_u w;
    tag = route_tag(addr);
    if (tag >= 0) exp_q[tag].push_back(data);
    if (addr[0] && addr < 2 * `NUM_LANES) begin
      w.payload = data;
      in_fwd[addr / 2]  = (w.ctrl.in_sel == IN_FORWARD);
      out_fwd[addr / 2] = (w.ctrl.out_sel == OUT_FORWARD);
    end
    while (cmd_cred == 0) begin
      @(posedge clk_i);
      #DRIVE_DLY;
    end
    cmd_valid_i = 1'b1;
    cmd_addr_i  = addr;
    cmd_data_i  = data;
    cmd_cred--;
    sent_count++;
    @(posedge clk_i);
    #DRIVE_DLY;
    cmd_valid_i = 1'b0;
  endtask

  // all responses in and every command credit back
  task automatic wait_drain();
    while (words_expected() != 0 || cmd_cred != `FIFO_DEPTH) begin
      @(posedge clk_i);
    end
    #DRIVE_DLY;
  endtask

  // ==============================
  // checks
  // ==============================
  assert property (@(posedge clk_i) (reset_i && reset_q) |-> (!rsp_valid_o && !cmd_credit_o))
    else begin
      proto_errs++;
      $display("response valid or command credit seen during reset");
    end

  assert property (@(posedge clk_i) (!reset_i && sent_count == 0) |-> !rsp_valid_o)
    else begin
      proto_errs++;
      $display("response valid before any command was sent");
    end

  always @(negedge clk_i) begin
    if (reset_i) begin
      rsp_owed    = `FIFO_DEPTH;
      rsp_pending = 0;
    end else begin
      if (cmd_credit_o) begin
        credits_seen++;
        cmd_cred++;
      end
      if (rsp_valid_o) begin
        assert (rsp_owed > 0) else begin
          proto_errs++;
          $display("response sent while the DUT held no response credit");
        end
        assert (!$isunknown(rsp_src_o) && exp_q[rsp_src_o].size() != 0) else begin
          proto_errs++;
          $display("unexpected response from source %0d, data %h", rsp_src_o, rsp_data_o);
        end
        if (!$isunknown(rsp_src_o) && exp_q[rsp_src_o].size() != 0) begin
          assert (rsp_data_o === exp_q[rsp_src_o][0]) else begin
            data_errs++;
            $display("FAIL rsp_data_o src %0d expected %h actual %h", rsp_src_o,
                     exp_q[rsp_src_o][0], rsp_data_o);
          end
          void'(exp_q[rsp_src_o].pop_front());
        end
        rsp_pending++;
      end
      rsp_owed = rsp_owed - int'(rsp_valid_o) + int'(rsp_credit_i);
    end
  end

  // response credits go back one per cycle unless held
  always begin
    @(posedge clk_i);
    #DRIVE_DLY;
    if (!reset_i && cycle >= hold_until && rsp_pending > 0) begin
      rsp_credit_i = 1'b1;
      rsp_pending--;
    end else begin
      rsp_credit_i = 1'b0;
    end
  end

  initial begin
    while (cycle < CYCLE_LIMIT) @(posedge clk_i);
    $display("run did not finish within %0d cycles, %0d responses missing", CYCLE_LIMIT,
             words_expected());
    $display("errors: data %0d protocol %0d", data_errs, proto_errs);
    $display(">>> FAIL");
    $finish;
  end

  // ==============================
  // stimulus
  // ==============================
  initial begin
    xbar_word_u cfg_w;
    reset_i      = 1'b1;
    reset_q      = 1'b0;
    cmd_valid_i  = 1'b0;
    cmd_addr_i   = '0;
    cmd_data_i   = '0;
    rsp_credit_i = 1'b0;
    for (int k = 0; k < `NUM_LANES; k++) begin
      in_fwd[k]  = 1'b0;
      out_fwd[k] = 1'b0;
    end
    repeat (RESET_CYCLES) @(posedge clk_i);
    #DRIVE_DLY;
    reset_i = 1'b0;

    // quiet cycles out of reset with nothing sent
    repeat (IDLE_CYCLES) @(posedge clk_i);
    #DRIVE_DLY;

    for (int i = 0; i < N_LOOP; i++) issue(cmd_addr_t'(`LOOPBACK_ADDR), rand_word());
    wait_drain();

    for (int i = 0; i < N_LANE; i++) begin
      issue(cmd_addr_t'(`LANE_INJ_ADDR(i % `NUM_LANES)), rand_word());
    end
    wait_drain();

    // lane 0 out to the ring, lane 1 takes the ring
    cfg_w = '0;
    cfg_w.ctrl.out_sel = OUT_FORWARD;
    issue(cmd_addr_t'(`LANE_CFG_ADDR(0)), cfg_w.payload);
    cfg_w = '0;
    cfg_w.ctrl.in_sel = IN_FORWARD;
    issue(cmd_addr_t'(`LANE_CFG_ADDR(1)), cfg_w.payload);
    for (int i = 0; i < 6; i++) issue(cmd_addr_t'(`LANE_INJ_ADDR(0)), rand_word());
    // these stay in lane 1 for good
    for (int i = 0; i < 3; i++) issue(cmd_addr_t'(`LANE_INJ_ADDR(1)), rand_word());
    wait_drain();

    for (int i = 0; i < N_DROP; i++) issue(cmd_addr_t'(7 + rand_word() % 9), rand_word());
    wait_drain();

    hold_until = cycle + HOLD_CYCLES;
    for (int i = 0; i < N_BP; i++) begin
      case (i % 3)
        0: issue(cmd_addr_t'(`LOOPBACK_ADDR), rand_word());
        1: issue(cmd_addr_t'(`LANE_INJ_ADDR(2)), rand_word());
        default: issue(cmd_addr_t'(`LANE_INJ_ADDR(0)), rand_word());
      endcase
    end
    wait_drain();
    repeat (SETTLE_CYCLES) @(posedge clk_i);

    assert (credits_seen == sent_count) else begin
      proto_errs++;
      $display("FAIL cmd_credit_o pulses expected %h actual %h", sent_count, credits_seen);
    end
    $display("errors: data %0d protocol %0d", data_errs, proto_errs);
    if (data_errs == 0 && proto_errs == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* design/fabric_top.sv */
`default_nettype none

`include "fabric_params.svh"

module fabric_top
  import fabric_msg_pkg::*;
(
  input  logic       clk_i,
  input  logic       reset_i,
  input  logic       cmd_valid_i,
  input  cmd_addr_t  cmd_addr_i,
  input  data_word_t cmd_data_i,
  output logic       cmd_credit_o,
  output logic       rsp_valid_o,
  output data_word_t rsp_data_o,
  output src_tag_t   rsp_src_o,
  input  logic       rsp_credit_i
);

  // router to lanes
  wire [`NUM_LANES-1:0] inj_valid;
  wire data_word_t      inj_data [`NUM_LANES];
  wire [`NUM_LANES-1:0] inj_credit;
  wire [`NUM_LANES-1:0] cfg_valid;
  wire data_word_t      cfg_data [`NUM_LANES];
  wire [`NUM_LANES-1:0] cfg_credit;
  // router to arbiter
  wire                  loop_valid;
  wire data_word_t      loop_data;
  wire                  loop_credit;
  // lanes to arbiter
  wire [`NUM_LANES-1:0] ret_valid;
  wire data_word_t      ret_data [`NUM_LANES];
  wire [`NUM_LANES-1:0] ret_credit;
  // ring, index is the sending lane
  wire [`NUM_LANES-1:0] ring_valid;
  wire data_word_t      ring_data [`NUM_LANES];
  wire [`NUM_LANES-1:0] ring_credit;

  cmd_router i_cmd_router (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .cmd_valid_i  (cmd_valid_i),
    .cmd_addr_i   (cmd_addr_i),
    .cmd_data_i   (cmd_data_i),
    .cmd_credit_o (cmd_credit_o),
    .inj_valid_o  (inj_valid),
    .inj_data_o   (inj_data),
    .inj_credit_i (inj_credit),
    .cfg_valid_o  (cfg_valid),
    .cfg_data_o   (cfg_data),
    .cfg_credit_i (cfg_credit),
    .loop_valid_o (loop_valid),
    .loop_data_o  (loop_data),
    .loop_credit_i(loop_credit)
  );

  // ==============================
  // lane ring
  // ==============================
  for (genvar k = 0; k < `NUM_LANES; k++) begin : g_lane
    // lane k is fed by the lane before it
    localparam int PREV = (k + `NUM_LANES - 1) % `NUM_LANES;

    xbar_lane i_xbar_lane (
      .clk_i       (clk_i),
      .reset_i     (reset_i),
      .inj_valid_i (inj_valid[k]),
      .inj_data_i  (inj_data[k]),
      .inj_credit_o(inj_credit[k]),
      .cfg_valid_i (cfg_valid[k]),
      .cfg_data_i  (cfg_data[k]),
      .cfg_credit_o(cfg_credit[k]),
      .fwd_valid_i (ring_valid[PREV]),
      .fwd_data_i  (ring_data[PREV]),
      .fwd_credit_o(ring_credit[PREV]),
      .ret_valid_o (ret_valid[k]),
      .ret_data_o  (ret_data[k]),
      .ret_credit_i(ret_credit[k]),
      .fwd_valid_o (ring_valid[k]),
      .fwd_data_o  (ring_data[k]),
      .fwd_credit_i(ring_credit[k])
    );
  end

  rsp_arbiter i_rsp_arbiter (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .ret_valid_i  (ret_valid),
    .ret_data_i   (ret_data),
    .ret_credit_o (ret_credit),
    .loop_valid_i (loop_valid),
    .loop_data_i  (loop_data),
    .loop_credit_o(loop_credit),
    .rsp_valid_o  (rsp_valid_o),
    .rsp_data_o   (rsp_data_o),
    .rsp_src_o    (rsp_src_o),
    .rsp_credit_i (rsp_credit_i)
  );

endmodule

`default_nettype wire

/* design/rsp_arbiter.sv */
`default_nettype none

`include "fabric_params.svh"

module rsp_arbiter
  import fabric_msg_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  logic [`NUM_LANES-1:0] ret_valid_i,
  input  data_word_t            ret_data_i [`NUM_LANES],
  output logic [`NUM_LANES-1:0] ret_credit_o,
  input  logic                  loop_valid_i,
  input  data_word_t            loop_data_i,
  output logic                  loop_credit_o,
  output logic                  rsp_valid_o,
  output data_word_t            rsp_data_o,
  output src_tag_t              rsp_src_o,
  input  logic                  rsp_credit_i
);

  localparam int CW = `CREDIT_BITS;
  localparam int NUM_SRC = `NUM_LANES + 1;
  localparam int LOOP_IDX = int'(LOOP_TAG);

  wire  [NUM_SRC-1:0] src_push;
  wire  [NUM_SRC-1:0] src_empty;
  wire  [NUM_SRC-1:0] src_credit;
  wire  data_word_t   src_push_data [NUM_SRC];
  wire  data_word_t   src_head [NUM_SRC];
  logic [NUM_SRC-1:0] src_pop;
  logic               grant;
  src_tag_t           grant_idx;
  src_tag_t           last_q;
  logic [CW-1:0]      rsp_cnt_q;

  // ==============================
  // source FIFOs, tag = index
  // ==============================
  for (genvar k = 0; k < `NUM_LANES; k++) begin : g_lane_src
    assign src_push[k]      = ret_valid_i[k];
    assign src_push_data[k] = ret_data_i[k];
    assign ret_credit_o[k]  = src_credit[k];
  end

  assign src_push[LOOP_IDX]      = loop_valid_i;
  assign src_push_data[LOOP_IDX] = loop_data_i;
  assign loop_credit_o           = src_credit[LOOP_IDX];

  for (genvar i = 0; i < NUM_SRC; i++) begin : g_src_fifo
    credit_fifo i_src_fifo (
      .clk_i      (clk_i),
      .reset_i    (reset_i),
      .push_i     (src_push[i]),
      .push_data_i(src_push_data[i]),
      .pop_i      (src_pop[i]),
      .empty_o    (src_empty[i]),
      .pop_data_o (src_head[i]),
      .credit_o   (src_credit[i])
    );
  end

  // round robin, search starts just past the last winner
  always_comb begin
    int idx;
    grant     = 1'b0;
    grant_idx = last_q;
    src_pop   = '0;
    for (int j = 1; j <= NUM_SRC; j++) begin
      idx = (int'(last_q) + j) % NUM_SRC;
      if (!grant && !src_empty[idx] && (rsp_cnt_q != '0)) begin
        grant        = 1'b1;
        grant_idx    = src_tag_t'(idx);
        src_pop[idx] = 1'b1;
      end
    end
  end

  // ==============================
  // response register
  // ==============================
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rsp_valid_o <= 1'b0;
      last_q      <= src_tag_t'(NUM_SRC - 1);
      rsp_cnt_q   <= CW'(`FIFO_DEPTH);
    end else begin
      rsp_valid_o <= grant;
      if (grant) begin
        last_q <= grant_idx;
      end
      // counted at grant, one cycle ahead of the registered valid
      rsp_cnt_q <= rsp_cnt_q - CW'(grant) + CW'(rsp_credit_i);
    end
  end

  always_ff @(posedge clk_i) begin
    if (grant) begin
      rsp_data_o <= src_head[grant_idx];
      rsp_src_o  <= grant_idx;
    end
  end

endmodule

`default_nettype wire

/* design/xbar_lane.sv */
`default_nettype none

`include "fabric_params.svh"

module xbar_lane
  import fabric_msg_pkg::*;
  import xbar_ctrl_pkg::*;
(
  input  logic       clk_i,
  input  logic       reset_i,
  // inject from router
  input  logic       inj_valid_i,
  input  data_word_t inj_data_i,
  output logic       inj_credit_o,
  // config from router
  input  logic       cfg_valid_i,
  input  data_word_t cfg_data_i,
  output logic       cfg_credit_o,
  // forward from previous lane
  input  logic       fwd_valid_i,
  input  data_word_t fwd_data_i,
  output logic       fwd_credit_o,
  // return to arbiter
  output logic       ret_valid_o,
  output data_word_t ret_data_o,
  input  logic       ret_credit_i,
  // forward to next lane
  output logic       fwd_valid_o,
  output data_word_t fwd_data_o,
  input  logic       fwd_credit_i
);

  localparam int CW = `CREDIT_BITS;

  xbar_word_u    inj_head;
  xbar_word_u    cfg_head;
  data_word_t    fwd_head;
  logic          inj_empty;
  logic          cfg_empty;
  logic          fwd_empty;
  logic          inj_pop;
  logic          cfg_pop;
  logic          fwd_pop;
  in_sel_e       in_sel_q;
  out_sel_e      out_sel_q;
  logic          src_empty;
  data_word_t    src_data;
  logic          dst_ready;
  logic          move;
  logic [1:0]    out_send;
  logic [1:0]    out_credit;
  logic [CW-1:0] out_cnt_q [2];

  // ==============================
  // receive FIFOs
  // ==============================
  credit_fifo #(
    .word_t(xbar_word_u)
  ) i_inj_fifo (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .push_i     (inj_valid_i),
    .push_data_i(inj_data_i),
    .pop_i      (inj_pop),
    .empty_o    (inj_empty),
    .pop_data_o (inj_head),
    .credit_o   (inj_credit_o)
  );

  credit_fifo #(
    .word_t(xbar_word_u)
  ) i_cfg_fifo (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .push_i     (cfg_valid_i),
    .push_data_i(cfg_data_i),
    .pop_i      (cfg_pop),
    .empty_o    (cfg_empty),
    .pop_data_o (cfg_head),
    .credit_o   (cfg_credit_o)
  );

  credit_fifo i_fwd_fifo (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .push_i     (fwd_valid_i),
    .push_data_i(fwd_data_i),
    .pop_i      (fwd_pop),
    .empty_o    (fwd_empty),
    .pop_data_o (fwd_head),
    .credit_o   (fwd_credit_o)
  );

  // config words are always taken, one per cycle
  assign cfg_pop = !cfg_empty;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      in_sel_q  <= IN_INJECT;
      out_sel_q <= OUT_RETURN;
    end else if (cfg_pop) begin
      in_sel_q  <= cfg_head.ctrl.in_sel;
      out_sel_q <= cfg_head.ctrl.out_sel;
    end
  end

  // ==============================
  // crossbar datapath
  // ==============================
  always_comb begin
    if (in_sel_q == IN_INJECT) begin
      src_empty = inj_empty;
      src_data  = inj_head.payload;
    end else begin
      src_empty = fwd_empty;
      src_data  = fwd_head;
    end
    dst_ready = (out_cnt_q[out_sel_q] != '0);
    move      = !src_empty && dst_ready;
  end

  // unselected input just holds its words
  assign inj_pop = move && (in_sel_q == IN_INJECT);
  assign fwd_pop = move && (in_sel_q == IN_FORWARD);

  assign out_send[0] = move && (out_sel_q == OUT_RETURN);
  assign out_send[1] = move && (out_sel_q == OUT_FORWARD);
  assign out_credit  = {fwd_credit_i, ret_credit_i};

  assign ret_valid_o = out_send[0];
  assign fwd_valid_o = out_send[1];
  assign ret_data_o  = src_data;
  assign fwd_data_o  = src_data;

  // output credit counters, index by out_sel
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int i = 0; i < 2; i++) begin
        out_cnt_q[i] <= CW'(`FIFO_DEPTH);
      end
    end else begin
      for (int i = 0; i < 2; i++) begin
        out_cnt_q[i] <= out_cnt_q[i] - CW'(out_send[i]) + CW'(out_credit[i]);
      end
    end
  end

endmodule

`default_nettype wire

/* design/cmd_router.sv */
`default_nettype none

`include "fabric_params.svh"

module cmd_router
  import fabric_msg_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  logic                  cmd_valid_i,
  input  cmd_addr_t             cmd_addr_i,
  input  data_word_t            cmd_data_i,
  output logic                  cmd_credit_o,
  output logic [`NUM_LANES-1:0] inj_valid_o,
  output data_word_t            inj_data_o [`NUM_LANES],
  input  logic [`NUM_LANES-1:0] inj_credit_i,
  output logic [`NUM_LANES-1:0] cfg_valid_o,
  output data_word_t            cfg_data_o [`NUM_LANES],
  input  logic [`NUM_LANES-1:0] cfg_credit_i,
  output logic                  loop_valid_o,
  output data_word_t            loop_data_o,
  input  logic                  loop_credit_i
);

  localparam int CW = `CREDIT_BITS;
  // inject and config per lane, then loopback
  localparam int NUM_LINKS = 2 * `NUM_LANES + 1;
  localparam int LOOP_LINK = 2 * `NUM_LANES;

  typedef logic [`ADDR_BITS+`DATA_BITS-1:0] ing_word_t;

  ing_word_t            head_word;
  cmd_addr_t            head_addr;
  data_word_t           head_data;
  logic                 head_empty;
  logic                 head_pop;
  logic                 blocked;
  logic [NUM_LINKS-1:0] link_hit;
  logic [NUM_LINKS-1:0] link_avail;
  logic [NUM_LINKS-1:0] link_valid;
  logic [NUM_LINKS-1:0] link_credit;
  logic [CW-1:0]        link_cnt_q [NUM_LINKS];

  credit_fifo #(
    .word_t(ing_word_t)
  ) i_ingress_fifo (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .push_i     (cmd_valid_i),
    .push_data_i({cmd_addr_i, cmd_data_i}),
    .pop_i      (head_pop),
    .empty_o    (head_empty),
    .pop_data_o (head_word),
    .credit_o   (cmd_credit_o)
  );

  assign head_addr = head_word[`ADDR_BITS+`DATA_BITS-1:`DATA_BITS];
  assign head_data = head_word[`DATA_BITS-1:0];

  // ==============================
  // address decode
  // ==============================
  for (genvar k = 0; k < `NUM_LANES; k++) begin : g_lane_link
    assign link_hit[2*k]    = (head_addr == cmd_addr_t'(`LANE_INJ_ADDR(k)));
    assign link_hit[2*k+1]  = (head_addr == cmd_addr_t'(`LANE_CFG_ADDR(k)));
    assign link_credit[2*k]   = inj_credit_i[k];
    assign link_credit[2*k+1] = cfg_credit_i[k];
    assign inj_valid_o[k] = link_valid[2*k];
    assign cfg_valid_o[k] = link_valid[2*k+1];
    assign inj_data_o[k]  = head_data;
    assign cfg_data_o[k]  = head_data;
  end

  assign link_hit[LOOP_LINK]    = (head_addr == cmd_addr_t'(`LOOPBACK_ADDR));
  assign link_credit[LOOP_LINK] = loop_credit_i;
  assign loop_valid_o           = link_valid[LOOP_LINK];
  assign loop_data_o            = head_data;

  // head waits only for its own destination, unmapped addresses drop
  always_comb begin
    for (int i = 0; i < NUM_LINKS; i++) begin
      link_avail[i] = (link_cnt_q[i] != '0);
    end
  end

  assign blocked    = |(link_hit & ~link_avail);
  assign head_pop   = !head_empty && !blocked;
  assign link_valid = {NUM_LINKS{head_pop}} & link_hit;

  // sender credit counters
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int i = 0; i < NUM_LINKS; i++) begin
        link_cnt_q[i] <= CW'(`FIFO_DEPTH);
      end
    end else begin
      for (int i = 0; i < NUM_LINKS; i++) begin
        link_cnt_q[i] <= link_cnt_q[i] - CW'(link_valid[i]) + CW'(link_credit[i]);
      end
    end
  end

endmodule

`default_nettype wire

/* design/credit_fifo.sv */
`default_nettype none

`include "fabric_params.svh"

module credit_fifo
  import fabric_msg_pkg::*;
#(
  parameter type word_t = data_word_t
) (
  input  logic  clk_i,
  input  logic  reset_i,
  input  logic  push_i,
  input  word_t push_data_i,
  input  logic  pop_i,
  output logic  empty_o,
  output word_t pop_data_o,
  output logic  credit_o
);

  localparam int PTR_BITS = $clog2(`FIFO_DEPTH);
  localparam int CW = `CREDIT_BITS;

  word_t               mem_q [`FIFO_DEPTH];
  logic [PTR_BITS-1:0] wr_ptr_q;
  logic [PTR_BITS-1:0] rd_ptr_q;
  logic [CW-1:0]       count_q;
  logic                do_push;
  logic                do_pop;

  // wrap at depth, depth need not be a power of two
  function automatic logic [PTR_BITS-1:0] next_ptr(input logic [PTR_BITS-1:0] ptr);
    if (ptr == PTR_BITS'(`FIFO_DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign empty_o    = (count_q == '0);
  assign do_pop     = pop_i && !empty_o;
  // sender credits keep a full FIFO from seeing a push
  assign do_push    = push_i && (count_q != CW'(`FIFO_DEPTH));
  assign pop_data_o = mem_q[rd_ptr_q];

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= push_data_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
      credit_o <= 1'b0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= next_ptr(wr_ptr_q);
      end
      if (do_pop) begin
        rd_ptr_q <= next_ptr(rd_ptr_q);
      end
      count_q  <= count_q + CW'(do_push) - CW'(do_pop);
      // one credit back per entry freed
      credit_o <= do_pop;
    end
  end

endmodule

`default_nettype wire

/* design/xbar_ctrl_pkg.sv */
`default_nettype none

`include "fabric_params.svh"

package xbar_ctrl_pkg;

  // input side of the lane crossbar
  typedef enum logic {
    IN_INJECT  = 1'b0,
    IN_FORWARD = 1'b1
  } in_sel_e;

  // output side of the lane crossbar
  typedef enum logic {
    OUT_RETURN  = 1'b0,
    OUT_FORWARD = 1'b1
  } out_sel_e;

  // ==============================
  // lane word, payload or control
  // ==============================
  typedef union packed {
    logic [`DATA_BITS-1:0] payload;
    struct packed {
      logic [`DATA_BITS-3:0] rsvd;
      out_sel_e              out_sel;
      in_sel_e               in_sel;
    } ctrl;
  } xbar_word_u;

endpackage

`default_nettype wire

/* design/fabric_msg_pkg.sv */
`default_nettype none

`include "fabric_params.svh"

package fabric_msg_pkg;

  // ==============================
  // link payload types
  // ==============================

  // command address as seen by the router
  typedef logic [`ADDR_BITS-1:0] cmd_addr_t;

  // raw word carried on every link
  typedef logic [`DATA_BITS-1:0] data_word_t;

  // response source, lanes first and loopback last
  typedef logic [1:0] src_tag_t;

  localparam src_tag_t LOOP_TAG = src_tag_t'(`NUM_LANES);

endpackage

`default_nettype wire

/* include/fabric_params.svh */
`ifndef FABRIC_PARAMS_SVH
`define FABRIC_PARAMS_SVH

// ==============================
// datapath widths
// ==============================
`define DATA_BITS 16
`define ADDR_BITS 4

// ==============================
// fabric sizing
// ==============================
`define NUM_LANES 3
// receiver FIFO depth, also the credits a sender starts with
`define FIFO_DEPTH 4
`define CREDIT_BITS ($clog2(`FIFO_DEPTH + 1))

// address map, lane k inject at 2k and config at 2k+1
`define LANE_INJ_ADDR(k) (2 * (k))
`define LANE_CFG_ADDR(k) (2 * (k) + 1)
`define LOOPBACK_ADDR 6

`endif
